/* bundleDecodeTb.sv */
`default_nettype none

module bundleDecodeTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumBundles  = 2000;
	localparam int ResetCycles = 8;
	localparam int CycleLimit  = NumBundles * 70 + ResetCycles + 2 * 64;

	logic clk;
	logic rst;
	logic icHit_i;
	logic [1:0] icFault_i;
	bundlePkg::bundle_t icBundle_i;
	logic [3:0] irq_i;
	logic [3:0] irqMask_i;
	logic [7:0] cause_i;
	logic intCommit_i;
	logic nextBundle_i;
	logic queued_i;
	logic cbWrEn_i;
	logic [5:0] cbWrAddr_i;
	bundlePkg::codeEntry_t cbWrData_i;
	logic freezeIp_o;
	bundlePkg::decoded_t decoded_o;
	logic lsmActive_o;

	// reference model state
	bundlePkg::codeEntry_t codeMem [64];
	bundlePkg::decoded_t expDec;
	bundlePkg::decoded_t prepared;
	logic expLsm;
	logic expDone;
	logic prepLsm;
	logic lastQueued;
	logic [31:0] rngState = 32'hccaa_e552;
	int cycleCount = 0;

	// stimulus for the next bundle
	bundlePkg::bundle_t stimBundle;
	logic [1:0] stimFault;
	logic [3:0] stimIrq;
	logic [3:0] stimMask;
	logic [7:0] stimCause;
	logic stimCommit;

	bundleDecodeTop #(.CodeDepth(64), .MaskBits(64)) bundleDecodeTop_inst (
		.clk(clk), .rst(rst), .icHit_i(icHit_i), .icFault_i(icFault_i),
		.icBundle_i(icBundle_i), .irq_i(irq_i), .irqMask_i(irqMask_i), .cause_i(cause_i),
		.intCommit_i(intCommit_i), .nextBundle_i(nextBundle_i), .queued_i(queued_i),
		.cbWrEn_i(cbWrEn_i), .cbWrAddr_i(cbWrAddr_i), .cbWrData_i(cbWrData_i),
		.freezeIp_o(freezeIp_o), .decoded_o(decoded_o), .lsmActive_o(lsmActive_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [271:0] got,
		input logic [271:0] exp);
		if (got !== exp) begin
			$display("error %s got %0h expected %0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ========================================
	// reference model
	// ========================================

	function automatic logic [39:0] breakWord(logic [7:0] cause, logic [3:0] level);
		return {1'b1, 9'd0, cause, 2'd0, level, bundlePkg::brkOpcode};
	endfunction

	function automatic bundlePkg::decoded_t prepare(bundlePkg::bundle_t b, logic [1:0] fault,
		logic [3:0] irq, logic [3:0] irqMask, logic [7:0] cause, logic commit,
		output logic startsLsm);
		bundlePkg::decoded_t d;
		bundlePkg::codeEntry_t entry;
		logic [2:0] units [3];
		logic [39:0] w;
		logic stop;
		d.bundle = b;
		d.tmpl = {3{b.tmpl}};
		d.insn = b.slot;
		stop = 1'b0;
		entry = codeMem[b.slot[0].regForm.rs1];
		for (int k = 0; k < 3; k++) begin
			units[k] = b.tmpl[6] ? bundlePkg::unitNone : {1'b0, b.tmpl[2 * k +: 2]};
		end
		// wide templates 7D..7F carry a single non-branch unit
		if (b.tmpl[6] && b.tmpl[6:0] >= 7'h7D) begin
			units[0] = 3'(b.tmpl[6:0] - 7'h7C);
		end
		startsLsm = 1'b0;
		if ((irq > irqMask && !commit) || fault != 2'd0 || b == '0) begin
			if (irq > irqMask && !commit)
				w = breakWord(cause, irq);
			else if (fault == 2'd1)
				w = breakWord(bundlePkg::faultTlb, 4'h0);
			else if (fault == 2'd2)
				w = breakWord(bundlePkg::faultExec, 4'h0);
			else
				w = breakWord(bundlePkg::faultBus, 4'h0);
			d.bundle = {bundlePkg::branchTemplate, w, w, w};
			d.tmpl = {3{bundlePkg::branchTemplate}};
			d.insn = {w, w, w};
			return d;
		end
		for (int k = 0; k < 3; k++) begin
			if (stop || units[k] != bundlePkg::unitBranch) begin
				// only branch slots are rewritten
			end
			else if (b.slot[k].regForm.opcode == bundlePkg::opBrk
				&& b.slot[k].regForm.funct5 == bundlePkg::fnPfi) begin
				stop = irq != 4'h0;
				for (int j = k; j < 3; j++) begin
					if (j == k || stop) begin
						d.bundle.slot[j] = (j == k && stop) ?
							breakWord(cause, irq) : bundlePkg::nopInsn;
						d.insn[j] = d.bundle.slot[j];
					end
				end
				if (stop && k == 0) begin
					d.bundle.tmpl = bundlePkg::branchTemplate;
					d.tmpl = {3{bundlePkg::branchTemplate}};
				end
				else if (stop && k == 1) begin
					d.bundle.tmpl = (units[0] == bundlePkg::unitNone) ? 8'hFF : {5'd0, units[0]};
					d.tmpl = {3{d.bundle.tmpl}};
				end
			end
			else if (b.slot[k].regForm.opcode == bundlePkg::opExec
				&& b.slot[k].regForm.funct5 == bundlePkg::fnExec) begin
				d.tmpl[k] = {1'b0, entry.tmpl};
				d.insn[k] = entry.insn;
			end
		end
		startsLsm = units[0] == bundlePkg::unitMemory
			&& b.slot[0].regForm.opcode == bundlePkg::opLsm
			&& (b.slot[0].regForm.funct5 == bundlePkg::fnLdm
			|| b.slot[0].regForm.funct5 == bundlePkg::fnStm);
		return d;
	endfunction

	// one queued cycle of the LDM/STM walk, lowest remaining register first
	task automatic applyQueued();
		logic [63:0] mask;
		logic [5:0] cur;
		logic ldm;
		if (lastQueued) begin
			mask = expDec.bundle[bundlePkg::maskLsb +: 64];
			if (expLsm && !expDone && mask != 64'd0) begin
				ldm = expDec.insn[0].regForm.funct5 == bundlePkg::fnLdm;
				cur = ldm ? expDec.insn[0].regForm.rd : expDec.insn[0].regForm.rs2;
				mask[cur] = 1'b0;
				expDec.bundle[bundlePkg::maskLsb +: 64] = mask;
				expDec.bundle[bundlePkg::countLsb +: 12] =
					expDec.bundle[bundlePkg::countLsb +: 12] + 12'd10;
				for (int i = 63; i >= 0; i--) begin
					if (mask[i])
						cur = 6'(i);
				end
				if (mask != 64'd0 && ldm)
					expDec.insn[0].regForm.rd = cur;
				else if (mask != 64'd0)
					expDec.insn[0].regForm.rs2 = cur;
			end
			else begin
				expDone = 1'b1;
			end
		end
	endtask

	task automatic compareOutputs();
		checkValue("decoded_o", decoded_o, expDec);
		checkValue("lsmActive_o", lsmActive_o, expLsm && !expDone);
	endtask

	// ========================================
	// stimulus
	// ========================================

	task automatic idleTick(input logic [31:0] r);
		@(posedge clk);
		icHit_i <= r[0];
		nextBundle_i <= !r[0] && r[1];
		queued_i <= r[3:2] != 2'd0;
		cbWrEn_i <= 1'b0;
		@(negedge clk);
		applyQueued();
		lastQueued = r[3:2] != 2'd0;
		compareOutputs();
	endtask

	task automatic writeCode(input logic [5:0] addr);
		bundlePkg::codeEntry_t e;
		e[31:0] = nextRand();
		e[47:32] = 16'(nextRand());
		@(posedge clk);
		cbWrEn_i <= 1'b1;
		cbWrAddr_i <= addr;
		cbWrData_i <= e;
		queued_i <= 1'b0;
		nextBundle_i <= 1'b0;
		@(negedge clk);
		applyQueued();
		lastQueued = 1'b0;
		codeMem[addr] = e;
		compareOutputs();
	endtask

	task automatic makeStimulus();
		logic [31:0] r;
		int k;
		r = nextRand();
		for (int i = 0; i < 4; i++) begin
			stimBundle[32 * i +: 32] = nextRand();
		end
		stimFault = 2'd0;
		stimIrq = r[4] ? r[11:8] : 4'h0;
		stimMask = r[15:12];
		stimCause = r[23:16];
		stimCommit = (stimIrq > stimMask) ? 1'b1 : r[5];
		stimBundle.tmpl[6] = r[24] & r[25] & r[26];
		k = int'(r[29:28]) % 3;
		case (r[3:0])
			4'd5, 4'd6: begin
				stimBundle.tmpl[6] = 1'b0;
				stimBundle.tmpl[2 * k +: 2] = 2'd0;
				stimBundle.slot[k].regForm.opcode = bundlePkg::opBrk;
				stimBundle.slot[k].regForm.funct5 = bundlePkg::fnPfi;
			end
			4'd7, 4'd8: begin
				stimBundle.tmpl[6:0] = {stimBundle.tmpl[6:2] & 5'h0F, 2'd0};
				stimBundle.slot[0].regForm.opcode = bundlePkg::opExec;
				stimBundle.slot[0].regForm.funct5 = bundlePkg::fnExec;
			end
			4'd9, 4'd10: begin
				stimBundle.tmpl[6:0] = {1'b0, stimBundle.tmpl[5:2], 2'd3};
				stimBundle.slot[0].regForm.opcode = bundlePkg::opLsm;
				stimBundle.slot[0].regForm.funct5 = r[27] ? bundlePkg::fnLdm : bundlePkg::fnStm;
				// sparse mask keeps the walk short
				stimBundle[bundlePkg::maskLsb +: 32] = nextRand() & nextRand() & nextRand();
				stimBundle[bundlePkg::maskLsb + 32 +: 32] = nextRand() & nextRand() & nextRand();
			end
			4'd11: stimBundle = '0;
			4'd12: stimFault = (r[29:28] == 2'd0) ? 2'd1 : r[29:28];
			4'd13: begin
				stimIrq = r[11:8] | 4'h1;
				stimMask = 4'(r[15:12] % stimIrq);
				stimCommit = 1'b0;
			end
			default: begin
			end
		endcase
	endtask

	task automatic driveAndAccept();
		@(posedge clk);
		icBundle_i <= stimBundle;
		icFault_i <= stimFault;
		irq_i <= stimIrq;
		irqMask_i <= stimMask;
		cause_i <= stimCause;
		intCommit_i <= stimCommit;
		icHit_i <= 1'b1;
		nextBundle_i <= 1'b1;
		queued_i <= 1'b0;
		cbWrEn_i <= 1'b0;
		@(negedge clk);
		applyQueued();
		lastQueued = 1'b0;
		compareOutputs();
		checkValue("freezeIp_o", freezeIp_o, stimIrq > stimMask && !stimCommit);
		prepared = prepare(stimBundle, stimFault, stimIrq, stimMask, stimCause, stimCommit,
			prepLsm);
		@(posedge clk);
		icHit_i <= 1'b0;
		nextBundle_i <= 1'b0;
		@(negedge clk);
		expDec = prepared;
		expLsm = prepLsm;
		expDone = 1'b0;
		compareOutputs();
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		rst = 1'b1;
		icHit_i = 1'b0;
		icFault_i = 2'd0;
		icBundle_i = '0;
		irq_i = 4'h0;
		irqMask_i = 4'h0;
		cause_i = 8'h00;
		intCommit_i = 1'b0;
		nextBundle_i = 1'b0;
		queued_i = 1'b0;
		cbWrEn_i = 1'b0;
		cbWrAddr_i = 6'd0;
		cbWrData_i = '0;
		lastQueued = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		// three NOPs on branch units and no walk in progress
		expDec.bundle = {bundlePkg::branchTemplate, {3{bundlePkg::nopInsn}}};
		expDec.tmpl = {3{bundlePkg::branchTemplate}};
		expDec.insn = {3{bundlePkg::nopInsn}};
		expLsm = 1'b0;
		expDone = 1'b1;
		@(negedge clk);
		compareOutputs();
		for (int a = 0; a < 64; a++) begin
			writeCode(6'(a));
		end
		for (int n = 0; n < NumBundles; n++) begin
			if (n % 200 == 199) begin
				repeat (4) writeCode(6'(nextRand() % 64));
			end
			makeStimulus();
			driveAndAccept();
			while (expLsm && !expDone) begin
				idleTick(nextRand());
			end
			repeat (nextRand() % 3) idleTick(nextRand());
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* bundleDecodeTop.sv */
`default_nettype none

module bundleDecodeTop #(
	parameter int CodeDepth = 64,
	parameter int MaskBits  = 64
) (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         icHit_i,
	input  wire logic [1:0]                   icFault_i,
	input  wire bundlePkg::bundle_t           icBundle_i,
	input  wire logic [3:0]                   irq_i,
	input  wire logic [3:0]                   irqMask_i,
	input  wire logic [7:0]                   cause_i,
	input  wire logic                         intCommit_i,
	input  wire logic                         nextBundle_i,
	input  wire logic                         queued_i,
	input  wire logic                         cbWrEn_i,
	input  wire logic [$clog2(CodeDepth)-1:0] cbWrAddr_i,
	input  wire bundlePkg::codeEntry_t        cbWrData_i,
	output logic                              freezeIp_o,
	output bundlePkg::decoded_t               decoded_o,
	output logic                              lsmActive_o
);

	bundlePkg::slotUnits_t units;
	bundlePkg::codeEntry_t codeEntry;
	logic [7:0] unitTemplate;
	logic [5:0] lsmCurrent;
	logic [5:0] nextReg;
	logic [MaskBits-1:0] maskCleared;
	logic maskEmpty;

	// LDM walks the rd field, STM walks rs2
	assign lsmCurrent = (decoded_o.insn[0].regForm.funct5 == bundlePkg::fnLdm) ?
		decoded_o.insn[0].regForm.rd : decoded_o.insn[0].regForm.rs2;

	templateDecoder templateDecoder_inst (
		.template_i     (icBundle_i.tmpl[6:0]),
		.units_o        (units),
		.unitTemplate_o (unitTemplate)
	);

	// EXEC address comes from slot 0 rs1
	codeBuffer #(.CodeDepth(CodeDepth)) codeBuffer_inst (
		.clk      (clk),
		.wrEn_i   (cbWrEn_i),
		.wrAddr_i (cbWrAddr_i),
		.wrData_i (cbWrData_i),
		.rdAddr_i (icBundle_i.slot[0].regForm.rs1[$clog2(CodeDepth)-1:0]),
		.rdData_o (codeEntry)
	);

	lsmSequencer #(.MaskBits(MaskBits)) lsmSequencer_inst (
		.mask_i        (decoded_o.bundle[bundlePkg::maskLsb +: MaskBits]),
		.current_i     (lsmCurrent),
		.nextReg_o     (nextReg),
		.maskCleared_o (maskCleared),
		.empty_o       (maskEmpty)
	);

	decodeBuffer decodeBuffer_inst (
		.clk            (clk),
		.rst            (rst),
		.irq_i          (irq_i),
		.irqMask_i      (irqMask_i),
		.cause_i        (cause_i),
		.intCommit_i    (intCommit_i),
		.icHit_i        (icHit_i),
		.icFault_i      (icFault_i),
		.icBundle_i     (icBundle_i),
		.units_i        (units),
		.unitTemplate_i (unitTemplate),
		.codeEntry_i    (codeEntry),
		.nextBundle_i   (nextBundle_i),
		.queued_i       (queued_i),
		.nextReg_i      (nextReg),
		.maskCleared_i  (maskCleared),
		.maskEmpty_i    (maskEmpty),
		.freezeIp_o     (freezeIp_o),
		.decoded_o      (decoded_o),
		.lsmActive_o    (lsmActive_o)
	);

endmodule

`default_nettype wire

/* bundlePkg.sv */
`default_nettype none

package bundlePkg;

	// ========================================
	// unit and fault encodings
	// ========================================

	typedef enum logic [2:0] {
		unitBranch  = 3'd0,
		unitInteger = 3'd1,
		unitFloat   = 3'd2,
		unitMemory  = 3'd3,
		unitNone    = 3'd7
	} unit_e;

	// cause byte carried in a fault break
	typedef enum logic [7:0] {
		faultTlb  = 8'h30,
		faultExec = 8'h31,
		faultBus  = 8'h32
	} faultCode_e;

	// ========================================
	// instruction word
	// ========================================

	typedef struct packed {
		logic [4:0]  funct5;
		logic [12:0] rest;
		logic [5:0]  rs2;
		logic [5:0]  rs1;
		logic [5:0]  rd;
		logic [3:0]  opcode;
	} regForm_t;

	typedef struct packed {
		logic        valid;
		logic [8:0]  zeroHi;
		logic [7:0]  cause;
		logic [1:0]  zeroLo;
		logic [3:0]  level;
		logic [15:0] opcode;
	} brkForm_t;

	typedef union packed {
		regForm_t regForm;
		brkForm_t brkForm;
	} insnWord_u;

	// ========================================
	// bundle and decoded output
	// ========================================

	// mask of an LDM/STM sits in bits 40..103, step count in bits 108..119
	typedef struct packed {
		logic [7:0]      tmpl;
		insnWord_u [2:0] slot;
	} bundle_t;

	typedef struct packed {
		unit_e slot2;
		unit_e slot1;
		unit_e slot0;
	} slotUnits_t;

	typedef struct packed {
		bundle_t         bundle;
		logic [2:0][7:0] tmpl;
		insnWord_u [2:0] insn;
	} decoded_t;

	typedef struct packed {
		logic       reserved;
		logic [6:0] tmpl;
		insnWord_u  insn;
	} codeEntry_t;

	localparam insnWord_u  nopInsn        = 40'h00_0000_000F;
	localparam logic [15:0] brkOpcode     = 16'h03C0;
	localparam logic [3:0] opBrk          = 4'h0;
	localparam logic [3:0] opExec         = 4'h2;
	localparam logic [3:0] opLsm          = 4'h6;
	localparam logic [4:0] fnExec         = 5'h05;
	localparam logic [4:0] fnPfi          = 5'h01;
	localparam logic [4:0] fnLdm          = 5'h0C;
	localparam logic [4:0] fnStm          = 5'h0D;
	localparam logic [7:0] branchTemplate = 8'h00;
	localparam int maskLsb                = 40;
	localparam int countLsb               = 108;

endpackage

`default_nettype wire

/* codeBuffer.sv */
`default_nettype none

module codeBuffer #(
	parameter int CodeDepth = 64
) (
	input  wire logic                         clk,
	input  wire logic                         wrEn_i,
	input  wire logic [$clog2(CodeDepth)-1:0] wrAddr_i,
	input  wire bundlePkg::codeEntry_t        wrData_i,
	input  wire logic [$clog2(CodeDepth)-1:0] rdAddr_i,
	output bundlePkg::codeEntry_t             rdData_o
);

	// template plus instruction words that EXEC pulls in
	bundlePkg::codeEntry_t mem [CodeDepth];

	// ========================================
	// write port
	// ========================================

	always_ff @(posedge clk) begin
		if (wrEn_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
	end

	// ========================================
	// read port
	// ========================================

	// asynchronous read, new contents show up right after the write edge
	assign rdData_o = mem[rdAddr_i];

	// an X stored here would later leak into a decoded slot
	wrDataKnown: assert property (@(posedge clk)
		wrEn_i |-> !$isunknown(wrData_i) && !$isunknown(wrAddr_i))
		else $error("code buffer write with unknown address or data");

endmodule

`default_nettype wire

/* decodeBuffer.sv */
`default_nettype none

module decodeBuffer (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [3:0]            irq_i,
	input  wire logic [3:0]            irqMask_i,
	input  wire logic [7:0]            cause_i,
	input  wire logic                  intCommit_i,
	input  wire logic                  icHit_i,
	input  wire logic [1:0]            icFault_i,
	input  wire bundlePkg::bundle_t    icBundle_i,
	input  wire bundlePkg::slotUnits_t units_i,
	input  wire logic [7:0]            unitTemplate_i,
	input  wire bundlePkg::codeEntry_t codeEntry_i,
	input  wire logic                  nextBundle_i,
	input  wire logic                  queued_i,
	input  wire logic [5:0]            nextReg_i,
	input  wire logic [63:0]           maskCleared_i,
	input  wire logic                  maskEmpty_i,
	output logic                       freezeIp_o,
	output bundlePkg::decoded_t        decoded_o,
	output logic                       lsmActive_o
);

	bundlePkg::decoded_t prep;
	bundlePkg::decoded_t held;
	bundlePkg::insnWord_u irqBrk;
	logic accept;
	logic stepping;
	logic recirc;
	logic maskLive;
	logic prepLsm;
	logic heldLsm;
	logic heldIsLdm;
	logic lsmDone;

	function automatic bundlePkg::insnWord_u brkWord(logic [7:0] cause, logic [3:0] level);
		bundlePkg::insnWord_u w;
		w.brkForm.valid  = 1'b1;
		w.brkForm.zeroHi = '0;
		w.brkForm.cause  = cause;
		w.brkForm.zeroLo = '0;
		w.brkForm.level  = level;
		w.brkForm.opcode = bundlePkg::brkOpcode;
		return w;
	endfunction

	// whole bundle replaced by one break, branch units everywhere
	function automatic bundlePkg::decoded_t allBreak(bundlePkg::insnWord_u w);
		bundlePkg::decoded_t d;
		d.bundle.tmpl = bundlePkg::branchTemplate;
		d.bundle.slot = {3{w}};
		d.tmpl        = {3{bundlePkg::branchTemplate}};
		d.insn        = {3{w}};
		return d;
	endfunction

	function automatic bundlePkg::unit_e unitOf(bundlePkg::slotUnits_t u, int k);
		case (k)
			0: return u.slot0;
			1: return u.slot1;
			default: return u.slot2;
		endcase
	endfunction

	function automatic logic isPfi(bundlePkg::unit_e u, bundlePkg::insnWord_u w);
		return u == bundlePkg::unitBranch && w.regForm.opcode == bundlePkg::opBrk
			&& w.regForm.funct5 == bundlePkg::fnPfi;
	endfunction

	function automatic logic isExec(bundlePkg::unit_e u, bundlePkg::insnWord_u w);
		return u == bundlePkg::unitBranch && w.regForm.opcode == bundlePkg::opExec
			&& w.regForm.funct5 == bundlePkg::fnExec;
	endfunction

	function automatic logic isLsm(bundlePkg::unit_e u, bundlePkg::insnWord_u w);
		return u == bundlePkg::unitMemory && w.regForm.opcode == bundlePkg::opLsm
			&& (w.regForm.funct5 == bundlePkg::fnLdm || w.regForm.funct5 == bundlePkg::fnStm);
	endfunction

	function automatic logic [7:0] faultCause(logic [1:0] fault);
		case (fault)
			2'd1: return bundlePkg::faultTlb;
			2'd2: return bundlePkg::faultExec;
			default: return bundlePkg::faultBus;
		endcase
	endfunction

	assign accept      = icHit_i && nextBundle_i;
	// hold the PC while an unmasked interrupt waits for commit
	assign freezeIp_o  = (irq_i > irqMask_i) && !intCommit_i;
	assign irqBrk      = brkWord(cause_i, irq_i);
	assign maskLive    = |held.bundle[bundlePkg::maskLsb +: 64];
	assign heldIsLdm   = held.insn[0].regForm.funct5 == bundlePkg::fnLdm;
	assign lsmActive_o = heldLsm && !lsmDone;
	assign recirc      = lsmActive_o && maskLive;
	assign stepping    = !accept && recirc && queued_i;
	assign decoded_o   = held;

	// ========================================
	// bundle preparation
	// ========================================

	always_comb begin
		logic pfiHit;
		pfiHit      = 1'b0;
		prep.bundle = icBundle_i;
		prep.tmpl   = {3{icBundle_i.tmpl}};
		prep.insn   = icBundle_i.slot;
		if (recirc) begin
			prep = held;
		end
		else if (freezeIp_o) begin
			prep = allBreak(irqBrk);
		end
		else if (icFault_i != 2'd0 || icBundle_i == '0) begin
			prep = allBreak(brkWord(faultCause(icFault_i), 4'h0));
		end
		else begin
			for (int k = 0; k < 3; k++) begin
				if (pfiHit) begin
					// slots after an interrupt break are already NOPs
				end
				else if (isPfi(unitOf(units_i, k), icBundle_i.slot[k])) begin
					prep.bundle.slot[k] = (irq_i == 4'h0) ? bundlePkg::nopInsn : irqBrk;
					prep.insn[k]        = (irq_i == 4'h0) ? bundlePkg::nopInsn : irqBrk;
					if (irq_i != 4'h0) begin
						pfiHit = 1'b1;
						for (int j = 0; j < 3; j++) begin
							if (j > k) begin
								prep.bundle.slot[j] = bundlePkg::nopInsn;
								prep.insn[j]        = bundlePkg::nopInsn;
							end
						end
						// later slots turned to NOPs, so the template has to follow
						if (k == 0) begin
							prep.bundle.tmpl = bundlePkg::branchTemplate;
							prep.tmpl        = {3{bundlePkg::branchTemplate}};
						end
						else if (k == 1) begin
							prep.bundle.tmpl = unitTemplate_i;
							prep.tmpl        = {3{unitTemplate_i}};
						end
					end
				end
				else if (isExec(unitOf(units_i, k), icBundle_i.slot[k])) begin
					prep.tmpl[k] = {1'b0, codeEntry_i.tmpl};
					prep.insn[k] = codeEntry_i.insn;
				end
			end
		end
		prepLsm = recirc ? heldLsm : isLsm(units_i.slot0, prep.insn[0]);
	end

	// ========================================
	// output register and LDM/STM expansion
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			held.bundle.tmpl <= bundlePkg::branchTemplate;
			held.bundle.slot <= {3{bundlePkg::nopInsn}};
			held.tmpl        <= {3{bundlePkg::branchTemplate}};
			held.insn        <= {3{bundlePkg::nopInsn}};
			heldLsm          <= 1'b0;
			lsmDone          <= 1'b1;
		end
		else if (accept) begin
			held    <= prep;
			heldLsm <= prepLsm;
			lsmDone <= 1'b0;
		end
		else if (stepping) begin
			held.bundle[bundlePkg::maskLsb +: 64]  <= maskCleared_i;
			held.bundle[bundlePkg::countLsb +: 12] <=
				held.bundle[bundlePkg::countLsb +: 12] + 12'd10;
			if (!maskEmpty_i) begin
				if (heldIsLdm)
					held.insn[0].regForm.rd <= nextReg_i;
				else
					held.insn[0].regForm.rs2 <= nextReg_i;
			end
		end
		else if (queued_i) begin
			lsmDone <= 1'b1;
		end
	end

	// no new bundle is taken while an LDM/STM step is due
	noAcceptOnStep: assert property (@(posedge clk) disable iff (rst)
		!(accept && recirc && queued_i))
		else $error("bundle accepted during LDM/STM step");

	faultKnown: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(icFault_i))
		else $error("icFault_i unknown");

endmodule

`default_nettype wire

/* filelist.f */
bundlePkg.sv
templateDecoder.sv
codeBuffer.sv
lsmSequencer.sv
decodeBuffer.sv
bundleDecodeTop.sv
bundleDecodeTb.sv

/* lsmSequencer.sv */
`default_nettype none

module lsmSequencer #(
	parameter int MaskBits = 64
) (
	input  wire logic [MaskBits-1:0] mask_i,
	input  wire logic [5:0]          current_i,
	output logic [5:0]               nextReg_o,
	output logic [MaskBits-1:0]      maskCleared_o,
	output logic                     empty_o
);

	logic [MaskBits-1:0] currentBit;
	logic [MaskBits-1:0] lowestBit;

	// ========================================
	// clear the register just issued
	// ========================================

	assign currentBit    = {{(MaskBits - 1){1'b0}}, 1'b1} << current_i;
	assign maskCleared_o = mask_i & ~currentBit;
	assign empty_o       = ~|maskCleared_o;

	// ========================================
	// pick the next register
	// ========================================

	// isolate the lowest remaining bit, two's complement trick
	assign lowestBit = maskCleared_o & (~maskCleared_o + 1'b1);

	// one-hot to index, stays on the current register once the mask is spent
	always_comb begin
		nextReg_o = current_i;
		for (int i = 0; i < MaskBits; i++) begin
			if (lowestBit[i]) begin
				nextReg_o = 6'(i);
			end
		end
	end

endmodule

`default_nettype wire

/* templateDecoder.sv */
`default_nettype none

module templateDecoder (
	input  wire logic [6:0]    template_i,
	output bundlePkg::slotUnits_t units_o,
	output logic [7:0]         unitTemplate_o
);

	// two-bit field of the template straight to a unit code
	function automatic bundlePkg::unit_e fieldUnit(logic [1:0] code);
		return bundlePkg::unit_e'({1'b0, code});
	endfunction

	// ========================================
	// slot units
	// ========================================

	always_comb begin
		units_o.slot2 = bundlePkg::unitNone;
		units_o.slot1 = bundlePkg::unitNone;
		units_o.slot0 = bundlePkg::unitNone;
		if (!template_i[6]) begin
			// slot 0 takes the low pair of bits
			units_o.slot0 = fieldUnit(template_i[1:0]);
			units_o.slot1 = fieldUnit(template_i[3:2]);
			units_o.slot2 = fieldUnit(template_i[5:4]);
		end
		else begin
			// single wide op, the other two slots are empty
			case (template_i)
				7'h7D: units_o.slot0 = bundlePkg::unitInteger;
				7'h7E: units_o.slot0 = bundlePkg::unitFloat;
				7'h7F: units_o.slot0 = bundlePkg::unitMemory;
				default: units_o.slot0 = bundlePkg::unitNone;
			endcase
		end
	end

	// ========================================
	// fallback template
	// ========================================

	// template that keeps only the slot 0 unit, rest branch
	always_comb begin
		case (units_o.slot0)
			bundlePkg::unitBranch:  unitTemplate_o = bundlePkg::branchTemplate;
			bundlePkg::unitInteger: unitTemplate_o = 8'h01;
			bundlePkg::unitFloat:   unitTemplate_o = 8'h02;
			bundlePkg::unitMemory:  unitTemplate_o = 8'h03;
			default:                unitTemplate_o = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire
